//--- source/fetch_pkg.sv
package fetch_pkg;

	// Reset vector sits in the uncached region.
	localparam logic [31:0] reset_vector = 32'h3000_0000;

	// Cacheable window, base inclusive and limit exclusive.
	localparam logic [31:0] cache_base = 32'hA000_0000;
	localparam logic [31:0] cache_limit = 32'hA200_0000;

	// Cache geometry.
	localparam int line_words = 8;
	localparam int line_count = 16;

	// Word select inside a line.
	localparam int word_bits = $clog2(line_words);
	// Byte offset inside a line, 32 bytes.
	localparam int offset_bits = word_bits + 2;
	localparam int index_bits = $clog2(line_count);
	localparam int tag_bits = 32 - offset_bits - index_bits;

	// Read channel burst opcodes.
	typedef enum logic [1:0] {
		burst_fixed = 2'b00,
		burst_incr  = 2'b01
	} burst_kind_t;

	// Fetch control states.
	typedef enum logic [2:0] {
		state_idle,
		state_lookup,
		state_refill,
		state_uncached,
		state_hold
	} fetch_state_t;

	// Read address request.
	typedef struct packed {
		logic [31:0] addr;
		// Beats minus one.
		logic [3:0]  len;
		burst_kind_t burst;
	} read_request_t;

	// One returned read beat.
	typedef struct packed {
		logic [31:0]          data;
		// Word position within the burst.
		logic [word_bits-1:0] beat;
		logic                 last;
	} refill_beat_t;

	// Packet handed to decode.
	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
	} fetch_packet_t;

endpackage

//--- source/icache_array.sv
module icache_array import fetch_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  lookup_strobe,
	input  logic [31:0]           lookup_addr,
	output logic                  hit,
	output logic [31:0]           hit_word,
	input  logic                  fill_strobe,
	input  logic [index_bits-1:0] fill_index,
	input  logic [tag_bits-1:0]   fill_tag,
	input  logic [word_bits-1:0]  fill_beat,
	input  logic [31:0]           fill_data,
	input  logic                  fill_last
);

	// Line data, tags and valid bits.
	logic [31:0] data_words [line_count][line_words];
	logic [tag_bits-1:0] tags [line_count];
	logic [line_count-1:0] valid_bits;

	logic [index_bits-1:0] lookup_index;
	logic [word_bits-1:0] lookup_word;
	logic [tag_bits-1:0] lookup_tag;

	// Address fields of the lookup.
	assign lookup_index = lookup_addr[offset_bits +: index_bits];
	assign lookup_word = lookup_addr[2 +: word_bits];
	assign lookup_tag = lookup_addr[31 -: tag_bits];

	// Valid bits and hit flag.
	always_ff @(posedge clock) begin
		if (reset) begin
			valid_bits <= '0;
			hit <= 1'b0;
		end else begin
			if (lookup_strobe) begin
				hit <= valid_bits[lookup_index] && (tags[lookup_index] == lookup_tag);
			end
			// Line is invalid while partly written.
			if (fill_strobe) begin
				valid_bits[fill_index] <= fill_last;
			end
		end
	end

	// Storage and registered word read.
	always_ff @(posedge clock) begin
		if (lookup_strobe) begin
			hit_word <= data_words[lookup_index][lookup_word];
		end
		if (fill_strobe) begin
			data_words[fill_index][fill_beat] <= fill_data;
			// Tag lands with the last beat.
			if (fill_last) begin
				tags[fill_index] <= fill_tag;
			end
		end
	end

endmodule

//--- source/burst_reader.sv
module burst_reader import fetch_pkg::*; (
	input  logic          clock,
	input  logic          reset,
	input  logic          start,
	input  read_request_t start_request,
	output logic          ar_valid,
	output read_request_t ar_request,
	input  logic          ar_ready,
	input  logic          r_valid,
	input  logic [31:0]   r_data,
	input  logic          r_last,
	output logic          r_ready,
	output logic          beat_valid,
	output refill_beat_t  beat,
	output logic          done
);

	// Read outstanding until the last beat.
	logic busy;
	logic [word_bits-1:0] beat_count;

	// Data channel always accepts.
	assign r_ready = 1'b1;

	// Only beats of our own read are forwarded.
	assign beat_valid = r_valid && busy;
	assign beat.data = r_data;
	assign beat.beat = beat_count;
	assign beat.last = r_last;
	assign done = beat_valid && r_last;

	// Address handshake and beat counting.
	always_ff @(posedge clock) begin
		if (reset) begin
			ar_valid <= 1'b0;
			busy <= 1'b0;
			beat_count <= '0;
		end else begin
			if (start) begin
				ar_valid <= 1'b1;
				busy <= 1'b1;
				beat_count <= '0;
			end else if (ar_valid && ar_ready) begin
				// Request taken by the slave.
				ar_valid <= 1'b0;
			end
			if (beat_valid) begin
				beat_count <= beat_count + 1'b1;
				if (r_last) begin
					busy <= 1'b0;
				end
			end
		end
	end

	// Request held stable until accepted.
	always_ff @(posedge clock) begin
		if (start) begin
			ar_request <= start_request;
		end
	end

endmodule

//--- source/fetch_control.sv
module fetch_control import fetch_pkg::*; (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  redirect,
	input  logic [31:0]           redirect_pc,
	input  logic                  out_ready,
	output logic                  out_valid,
	output fetch_packet_t         out_packet,
	output logic                  lookup_strobe,
	output logic [31:0]           lookup_addr,
	input  logic                  hit,
	input  logic [31:0]           hit_word,
	output logic                  start,
	output read_request_t         start_request,
	input  logic                  beat_valid,
	input  refill_beat_t          beat,
	input  logic                  done,
	output logic                  fill_strobe,
	output logic [index_bits-1:0] fill_index,
	output logic [tag_bits-1:0]   fill_tag
);

	fetch_state_t state;
	// Address of the next packet owed to decode.
	logic [31:0] pc;
	// Address of the fetch currently in flight.
	logic [31:0] fetch_pc;
	// In-flight fetch belongs to a dropped path.
	logic stale;
	// Wanted word caught during a refill.
	logic [31:0] captured_word;

	logic [31:0] next_pc;
	logic [31:0] target_pc;
	logic [31:0] issue_pc;
	logic [31:0] fetched_word;
	logic stale_now;
	logic lookup_done;
	logic word_done;
	logic beat_match;
	logic issue;
	logic issue_cached;
	logic deliver;
	logic miss_start;

	// Sequential next pc, no dnpc from later stages.
	assign next_pc = pc + 32'd4;
	// A redirect this cycle wins over the stored pc.
	assign target_pc = redirect ? redirect_pc : pc;
	assign stale_now = stale | redirect;

	// Cache result is valid the cycle after the strobe.
	assign lookup_done = (state == state_lookup) && !lookup_strobe;
	assign word_done = ((state == state_uncached) && beat_valid) ||
		((state == state_refill) && done);

	// Beat carrying the word at the fetch offset.
	assign beat_match = beat_valid && (beat.beat == fetch_pc[offset_bits-1:2]);

	always_comb begin
		if (state == state_lookup) begin
			fetched_word = hit_word;
		end else if ((state == state_uncached) || beat_match) begin
			fetched_word = beat.data;
		end else begin
			fetched_word = captured_word;
		end
	end

	// New fetch from idle, from hold on accept or drop, or after a stale fetch ends.
	assign issue = (state == state_idle) ||
		((state == state_hold) && (redirect || out_ready)) ||
		((lookup_done || word_done) && stale_now);
	assign issue_pc = ((state == state_hold) && !redirect) ? next_pc : target_pc;
	assign issue_cached = (issue_pc >= cache_base) && (issue_pc < cache_limit);

	assign miss_start = lookup_done && !hit && !stale_now;
	assign deliver = ((lookup_done && hit) || word_done) && !stale_now;

	// Cache side addressing follows the in-flight fetch.
	assign lookup_addr = fetch_pc;
	assign fill_strobe = (state == state_refill) && beat_valid;
	assign fill_index = fetch_pc[offset_bits +: index_bits];
	assign fill_tag = fetch_pc[31 -: tag_bits];

	// Control state.
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= state_idle;
			pc <= reset_vector;
			fetch_pc <= reset_vector;
			stale <= 1'b0;
			out_valid <= 1'b0;
			lookup_strobe <= 1'b0;
			start <= 1'b0;
		end else begin
			// Strobes last one cycle.
			lookup_strobe <= 1'b0;
			start <= 1'b0;
			if (redirect) begin
				pc <= redirect_pc;
			end
			if (issue) begin
				// Any held packet is dropped or already taken.
				fetch_pc <= issue_pc;
				pc <= issue_pc;
				stale <= 1'b0;
				out_valid <= 1'b0;
				if (issue_cached) begin
					lookup_strobe <= 1'b1;
					state <= state_lookup;
				end else begin
					start <= 1'b1;
					state <= state_uncached;
				end
			end else if (miss_start) begin
				start <= 1'b1;
				state <= state_refill;
			end else if (deliver) begin
				out_valid <= 1'b1;
				state <= state_hold;
			end else if (redirect) begin
				// Let the running fetch finish, then discard it.
				stale <= 1'b1;
			end
		end
	end

	// Payload registers.
	always_ff @(posedge clock) begin
		if (issue) begin
			start_request.addr <= issue_pc;
			start_request.len <= 4'd0;
			start_request.burst <= burst_fixed;
		end else if (miss_start) begin
			// Whole line, aligned to 32 bytes.
			start_request.addr <= {fetch_pc[31:offset_bits], {offset_bits{1'b0}}};
			start_request.len <= 4'(line_words - 1);
			start_request.burst <= burst_incr;
		end
		if ((state == state_refill) && beat_match) begin
			captured_word <= beat.data;
		end
		if (deliver) begin
			out_packet.pc <= fetch_pc;
			out_packet.inst <= fetched_word;
		end
	end

endmodule

//--- source/fetch_unit.sv
module fetch_unit import fetch_pkg::*; (
	input  logic          clock,
	input  logic          reset,
	input  logic          redirect,
	input  logic [31:0]   redirect_pc,
	output logic          out_valid,
	output fetch_packet_t out_packet,
	input  logic          out_ready,
	output logic          ar_valid,
	output read_request_t ar_request,
	input  logic          ar_ready,
	input  logic          r_valid,
	input  logic [31:0]   r_data,
	input  logic          r_last,
	output logic          r_ready
);

	// Control to cache.
	logic lookup_strobe;
	logic [31:0] lookup_addr;
	logic hit;
	logic [31:0] hit_word;
	logic fill_strobe;
	logic [index_bits-1:0] fill_index;
	logic [tag_bits-1:0] fill_tag;

	// Control to reader.
	logic start;
	read_request_t start_request;
	logic beat_valid;
	refill_beat_t beat;
	logic done;

	fetch_control fetch_control_inst (
		.clock         (clock),
		.reset         (reset),
		.redirect      (redirect),
		.redirect_pc   (redirect_pc),
		.out_ready     (out_ready),
		.out_valid     (out_valid),
		.out_packet    (out_packet),
		.lookup_strobe (lookup_strobe),
		.lookup_addr   (lookup_addr),
		.hit           (hit),
		.hit_word      (hit_word),
		.start         (start),
		.start_request (start_request),
		.beat_valid    (beat_valid),
		.beat          (beat),
		.done          (done),
		.fill_strobe   (fill_strobe),
		.fill_index    (fill_index),
		.fill_tag      (fill_tag)
	);

	// Fill beats come straight from the reader.
	icache_array icache_array_inst (
		.clock         (clock),
		.reset         (reset),
		.lookup_strobe (lookup_strobe),
		.lookup_addr   (lookup_addr),
		.hit           (hit),
		.hit_word      (hit_word),
		.fill_strobe   (fill_strobe),
		.fill_index    (fill_index),
		.fill_tag      (fill_tag),
		.fill_beat     (beat.beat),
		.fill_data     (beat.data),
		.fill_last     (beat.last)
	);

	burst_reader burst_reader_inst (
		.clock         (clock),
		.reset         (reset),
		.start         (start),
		.start_request (start_request),
		.ar_valid      (ar_valid),
		.ar_request    (ar_request),
		.ar_ready      (ar_ready),
		.r_valid       (r_valid),
		.r_data        (r_data),
		.r_last        (r_last),
		.r_ready       (r_ready),
		.beat_valid    (beat_valid),
		.beat          (beat),
		.done          (done)
	);

endmodule

//--- tests/memory_model.sv
module memory_model import fetch_pkg::*; (
	input  logic          clock,
	input  logic          reset,
	// High lets the channel move this cycle.
	input  logic          ar_allow,
	input  logic          r_allow,
	input  logic          ar_valid,
	input  read_request_t ar_request,
	output logic          ar_ready,
	output logic          r_valid,
	output logic [31:0]   r_data,
	output logic          r_last,
	input  logic          r_ready
);
	timeunit 1ns;
	timeprecision 1ps;

	// One read outstanding at a time.
	logic busy;
	logic [31:0] beat_addr;
	logic [3:0] beats_left;
	burst_kind_t kind;

	always @(posedge clock) begin
		if (reset) begin
			ar_ready <= 1'b0;
			r_valid <= 1'b0;
			r_data <= '0;
			r_last <= 1'b0;
			busy <= 1'b0;
			beat_addr <= '0;
			beats_left <= '0;
			kind <= burst_fixed;
		end else begin
			if (ar_valid && ar_ready) begin
				busy <= 1'b1;
				beat_addr <= ar_request.addr;
				beats_left <= ar_request.len;
				kind <= ar_request.burst;
				ar_ready <= 1'b0;
			end else begin
				// Random address gaps.
				ar_ready <= !busy && ar_allow;
			end
			if (busy && (!r_valid || r_ready)) begin
				if (r_allow) begin
					r_valid <= 1'b1;
					// Image word is the address with the upper half inverted.
					r_data <= {~beat_addr[31:16], beat_addr[15:0]};
					r_last <= (beats_left == 4'd0);
					if (kind == burst_incr) begin
						beat_addr <= beat_addr + 32'd4;
					end
					beats_left <= beats_left - 4'd1;
					if (beats_left == 4'd0) begin
						busy <= 1'b0;
					end
				end else begin
					// Data gap.
					r_valid <= 1'b0;
					r_last <= 1'b0;
				end
			end else if (r_valid && r_ready) begin
				r_valid <= 1'b0;
				r_last <= 1'b0;
			end
		end
	end

endmodule

//--- tests/fetch_tb.sv
module fetch_tb import fetch_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int reset_cycles = 16;
	localparam int uncached_words = 16;
	localparam int cached_words = 64;
	// Bytes covered by the cached block.
	localparam logic [31:0] block_bytes = 32'(cached_words * 4);
	localparam int word_total = uncached_words + 2 * cached_words;
	// Budget of 27 cycles per word, plus reset and redirect slack.
	localparam int timeout_cycles = reset_cycles + 27 * word_total + 96;

	logic clock;
	logic reset;
	logic redirect;
	logic [31:0] redirect_pc;
	logic out_ready;
	logic out_valid;
	fetch_packet_t out_packet;
	logic ar_valid;
	read_request_t ar_request;
	logic ar_ready;
	logic r_valid;
	logic [31:0] r_data;
	logic r_last;
	logic r_ready;

	// Per-cycle random draws.
	logic [15:0] lfsr_state = 16'd3052;
	logic ar_allow = 1'b0;
	logic r_allow = 1'b0;
	logic ready_roll = 1'b0;
	logic redirect_roll = 1'b0;

	// Reference model state.
	int cycle_count = 0;
	logic [31:0] expected_pc;
	logic [31:0] target_pc;
	logic awaiting_target;
	logic second_pass;
	int pass_two_taken;

	fetch_unit fetch_unit_inst (
		.clock       (clock),
		.reset       (reset),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.out_valid   (out_valid),
		.out_packet  (out_packet),
		.out_ready   (out_ready),
		.ar_valid    (ar_valid),
		.ar_request  (ar_request),
		.ar_ready    (ar_ready),
		.r_valid     (r_valid),
		.r_data      (r_data),
		.r_last      (r_last),
		.r_ready     (r_ready)
	);

	memory_model memory_model_inst (
		.clock      (clock),
		.reset      (reset),
		.ar_allow   (ar_allow),
		.r_allow    (r_allow),
		.ar_valid   (ar_valid),
		.ar_request (ar_request),
		.ar_ready   (ar_ready),
		.r_valid    (r_valid),
		.r_data     (r_data),
		.r_last     (r_last),
		.r_ready    (r_ready)
	);

	// 16-bit Fibonacci LFSR, taps 16 14 13 11.
	function automatic logic [15:0] lfsr_next(input logic [15:0] value);
		return {value[14:0], value[15] ^ value[13] ^ value[12] ^ value[10]};
	endfunction

	// Word the memory holds at a given address.
	function automatic logic [31:0] expected_inst(input logic [31:0] addr);
		return {~addr[31:16], addr[15:0]};
	endfunction

	function automatic logic in_window(input logic [31:0] addr);
		return (addr >= cache_base) && (addr < cache_limit);
	endfunction

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string reason);
		abort_run($sformatf("Fail at %0d ns: %s", $time, reason));
	endtask

	// Accept a number of packets under random back-pressure.
	task automatic take_words(input int count);
		int taken;
		taken = 0;
		while (taken < count) begin
			@(posedge clock);
			if (out_valid && out_ready) begin
				taken++;
			end
			if (taken < count) begin
				out_ready <= ready_roll;
			end else begin
				out_ready <= 1'b0;
			end
		end
	endtask

	// Redirect at a random cycle, decode stalled.
	task automatic steer(input logic [31:0] target);
		@(posedge clock);
		while (!redirect_roll) begin
			@(posedge clock);
		end
		redirect <= 1'b1;
		redirect_pc <= target;
		out_ready <= 1'b0;
		@(posedge clock);
		redirect <= 1'b0;
	endtask

	initial begin
		clock = 1'b0;
		forever begin
			#2 clock = ~clock;
		end
	end

	// Seven bits per cycle, always in the same order.
	always @(posedge clock) begin : draw_block
		logic [6:0] draw;
		for (int i = 0; i < 7; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			draw[i] = lfsr_state[0];
		end
		ar_allow <= draw[0];
		r_allow <= draw[1] | draw[2];
		ready_roll <= draw[3] | draw[4];
		redirect_roll <= draw[5] & draw[6];
	end

	// Expected pc, redirect target and second pass count.
	always @(posedge clock) begin
		if (reset) begin
			expected_pc <= reset_vector;
			target_pc <= reset_vector;
			awaiting_target <= 1'b0;
			pass_two_taken <= 0;
		end else if (redirect) begin
			expected_pc <= redirect_pc;
			target_pc <= redirect_pc;
			awaiting_target <= 1'b1;
		end else if (out_valid && out_ready) begin
			expected_pc <= expected_pc + 32'd4;
			awaiting_target <= 1'b0;
			if (second_pass) begin
				pass_two_taken <= pass_two_taken + 1;
			end
		end
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			abort_run($sformatf("Timeout: run did not end within %0d cycles", timeout_cycles));
		end
	end

	// Quiet through reset and the first cycle out of it.
	reset_quiet: assert property (@(posedge clock)
		(cycle_count != 0 && (reset || $past(reset))) |-> (!out_valid && !ar_valid))
		else report_mismatch("out_valid or ar_valid high around reset");

	packet_value: assert property (@(posedge clock) disable iff (reset)
		(out_valid && out_ready) |->
		(out_packet.pc == expected_pc && out_packet.inst == expected_inst(out_packet.pc)))
		else report_mismatch($sformatf("packet pc %h inst %h, expected pc %h",
			$sampled(out_packet.pc), $sampled(out_packet.inst), $sampled(expected_pc)));

	held_packet: assert property (@(posedge clock) disable iff (reset)
		(out_valid && !out_ready && !redirect) |=> (out_valid && $stable(out_packet)))
		else report_mismatch("packet changed under back-pressure");

	// Dropped packet and first packet of the new path.
	redirect_drop: assert property (@(posedge clock) disable iff (reset)
		redirect |=> !out_valid)
		else report_mismatch("out_valid still high after redirect");

	// Nothing but the target is even offered until it is taken.
	redirect_target: assert property (@(posedge clock) disable iff (reset)
		(out_valid && awaiting_target) |-> (out_packet.pc == target_pc))
		else report_mismatch($sformatf("packet offered after redirect has pc %h",
			$sampled(out_packet.pc)));

	cached_request: assert property (@(posedge clock) disable iff (reset)
		(ar_valid && in_window(ar_request.addr)) |->
		(ar_request.addr[4:0] == 5'd0 && ar_request.len == 4'd7 && ar_request.burst == burst_incr))
		else report_mismatch($sformatf("bad line request at %h", $sampled(ar_request.addr)));

	uncached_request: assert property (@(posedge clock) disable iff (reset)
		(ar_valid && !in_window(ar_request.addr)) |->
		(ar_request.len == 4'd0 && ar_request.burst == burst_fixed))
		else report_mismatch($sformatf("bad single request at %h", $sampled(ar_request.addr)));

	request_stable: assert property (@(posedge clock) disable iff (reset)
		(ar_valid && !ar_ready) |=> (ar_valid && $stable(ar_request)))
		else report_mismatch("read request changed before handshake");

	// Data channel never stalls.
	read_ready: assert property (@(posedge clock) disable iff (reset)
		r_ready)
		else report_mismatch("r_ready low out of reset");

	// Only the stale line past the block may still be read.
	no_refetch: assert property (@(posedge clock) disable iff (reset)
		(second_pass && pass_two_taken < cached_words && ar_valid && ar_ready) |->
		(pass_two_taken == 0 && ar_request.addr == cache_base + block_bytes))
		else report_mismatch($sformatf("read at %h in second pass", $sampled(ar_request.addr)));

	initial begin
		reset = 1'b1;
		redirect = 1'b0;
		redirect_pc = '0;
		out_ready = 1'b0;
		second_pass = 1'b0;
		repeat (reset_cycles) @(posedge clock);
		reset <= 1'b0;
		// Uncached words from the reset vector.
		take_words(uncached_words);
		// First pass fills eight lines.
		steer(cache_base);
		take_words(cached_words);
		// Same block again, all hits.
		second_pass <= 1'b1;
		steer(cache_base);
		take_words(cached_words);
		$display("PASS: all tests");
		$finish;
	end

endmodule

//--- sources.f
source/fetch_pkg.sv
source/icache_array.sv
source/burst_reader.sv
source/fetch_control.sv
source/fetch_unit.sv
tests/memory_model.sv
tests/fetch_tb.sv

//--- Bender.yml
package:
  name: fetch_unit

sources:
  # RTL
  - files:
      - source/fetch_pkg.sv
      - source/icache_array.sv
      - source/burst_reader.sv
      - source/fetch_control.sv
      - source/fetch_unit.sv
  # Testbench
  - target: test
    files:
      - tests/memory_model.sv
      - tests/fetch_tb.sv
